//--- hw/mem_consts.svh
/*
   Shared widths, store buffer depth and MIPS load/store opcodes.
   Include this header wherever one of these constants is needed.
*/
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Datapath and bus widths
`define MEM_DATA_BITS   32
`define MEM_ADDR_BITS   32
`define MEM_WADDR_BITS  30

// Store buffer holds 2**SB_PTR_BITS slots, one kept free
`define SB_PTR_BITS     3

// ------------------------------
// Major opcodes, loads then stores
`define OP_LB   6'h20
`define OP_LH   6'h21
`define OP_LWL  6'h22
`define OP_LW   6'h23
`define OP_LBU  6'h24
`define OP_LHU  6'h25
`define OP_LWR  6'h26
`define OP_SB   6'h28
`define OP_SH   6'h29
`define OP_SWL  6'h2A
`define OP_SW   6'h2B
`define OP_SWR  6'h2E

`endif

//--- hw/mem_op_pkg.sv
/*
   Pipeline-side types: the opcode enum, one memory request, and the
   control FSM state encoding.
*/
`include "mem_consts.svh"

package mem_op_pkg;

   // Load and store opcodes understood by the memory stage
   typedef enum logic [5:0] {
      OP_LB  = `OP_LB,
      OP_LH  = `OP_LH,
      OP_LWL = `OP_LWL,
      OP_LW  = `OP_LW,
      OP_LBU = `OP_LBU,
      OP_LHU = `OP_LHU,
      OP_LWR = `OP_LWR,
      OP_SB  = `OP_SB,
      OP_SH  = `OP_SH,
      OP_SWL = `OP_SWL,
      OP_SW  = `OP_SW,
      OP_SWR = `OP_SWR
   } mem_op_e;

   // One request from the pipeline
   // rt_val is the store source and also the LWL/LWR merge target
   typedef struct packed {
      mem_op_e                   op;
      logic [`MEM_ADDR_BITS-1:0] address;
      logic [`MEM_DATA_BITS-1:0] rt_val;
   } mem_req_t;

   // Control FSM, loads only
   typedef enum logic [1:0] {
      IDLE,
      LOAD_ISSUE,
      LOAD_WAIT
   } ctrl_state_e;

endpackage

//--- hw/mem_bus_pkg.sv
/*
   Memory-side types: a buffered store and the command half of the
   word-addressed data memory bus.
*/
`include "mem_consts.svh"

package mem_bus_pkg;

   // One store waiting in the store buffer
   typedef struct packed {
      logic [`MEM_WADDR_BITS-1:0]  waddr;
      logic [`MEM_DATA_BITS-1:0]   data;
      logic [`MEM_DATA_BITS/8-1:0] byteena;
   } sb_entry_t;

   // Command side of the data memory bus
   // Held unchanged while dmem_waitrequest is high
   typedef struct packed {
      logic                        read;
      logic                        write;
      logic [`MEM_WADDR_BITS-1:0]  waddr;
      logic [`MEM_DATA_BITS-1:0]   writedata;
      logic [`MEM_DATA_BITS/8-1:0] byteena;
   } dmem_cmd_t;

endpackage

//--- hw/store_align.sv
/*
   Turns a store request into a store buffer entry: rotated data,
   big-endian byte enables and word address. Purely combinational.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module store_align import mem_op_pkg::*, mem_bus_pkg::*; (
   input  mem_req_t  req_data,
   output sb_entry_t entry
);

   logic [1:0]                  rot_delta;
   logic [1:0]                  rot;
   logic [2*`MEM_DATA_BITS-1:0] rt_twice;
   logic [1:0]                  ofs;

   assign ofs = req_data.address[1:0];

   // Extra rotation per opcode on top of the byte offset
   always_comb begin
      case (req_data.op)
         OP_SH:         rot_delta = 2'd2;
         OP_SB, OP_SWR: rot_delta = 2'd1;
         default:       rot_delta = 2'd0;  // SW, SWL
      endcase
   end

   // Two-bit sum wraps, which is the rotation we want
   assign rot      = ofs + rot_delta;
   assign rt_twice = {req_data.rt_val, req_data.rt_val};

   // Rotate right by whole bytes
   assign entry.data = rt_twice[8*rot +: `MEM_DATA_BITS];

   // ------------------------------
   // Byte enables, byte 0 is bits 31:24
   always_comb begin
      case (req_data.op)
         OP_SW:   entry.byteena = 4'hF;
         OP_SH:   entry.byteena = ofs[1] ? 4'h3 : 4'hC;
         OP_SB:   entry.byteena = 4'h8 >> ofs;
         OP_SWL:  entry.byteena = 4'hF >> ofs;   // bytes k..3
         OP_SWR:  entry.byteena = 4'hF << ~ofs;  // bytes 0..k
         default: entry.byteena = 4'h0;
      endcase
   end

   assign entry.waddr = req_data.address[`MEM_ADDR_BITS-1:2];

endmodule

//--- hw/store_buffer.sv
/*
   Circular store queue between the pipeline and the data memory bus.
   One slot stays free so that full and empty are told apart.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module store_buffer import mem_bus_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  logic      push,
   input  sb_entry_t push_entry,
   input  logic      pop,
   output sb_entry_t head,
   output logic      full,
   output logic      empty
);

   localparam int SLOTS = 1 << `SB_PTR_BITS;

   sb_entry_t               slots [SLOTS];
   logic [`SB_PTR_BITS-1:0] wp;
   logic [`SB_PTR_BITS-1:0] rp;
   logic [`SB_PTR_BITS-1:0] wp_next;

   assign wp_next = wp + 1'b1;

   // Flags straight from the pointers
   assign full  = (wp_next == rp);
   assign empty = (wp == rp);
   assign head  = slots[rp];

   // ------------------------------
   // Pointers
   always_ff @(posedge clock) begin
      if (reset) begin
         wp <= '0;
         rp <= '0;
      end else begin
         if (push)
            wp <= wp_next;
         // Controller only pops a non-empty buffer
         if (pop)
            rp <= rp + 1'b1;
      end
   end

   // Entry storage
   always_ff @(posedge clock) begin
      if (push)
         slots[wp] <= push_entry;
   end

endmodule

//--- hw/load_extract.sv
/*
   Load result network. Latches the load on capture, then picks bytes,
   extends or merges with rt when the read word returns.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module load_extract import mem_op_pkg::*; (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      capture,
   input  mem_req_t                  req_data,
   input  logic                      readdatavalid,
   input  logic [`MEM_DATA_BITS-1:0] readdata,
   output logic                      load_done,
   output logic [`MEM_DATA_BITS-1:0] load_result
);

   mem_op_e                   op_q;
   logic [1:0]                ofs_q;
   logic [`MEM_DATA_BITS-1:0] rt_q;
   logic [7:0]                bsel;
   logic [15:0]               hsel;
   logic [`MEM_DATA_BITS-1:0] res;

   // Held for the whole load, the requester may move on
   always_ff @(posedge clock) begin
      if (capture) begin
         op_q  <= req_data.op;
         ofs_q <= req_data.address[1:0];
         rt_q  <= req_data.rt_val;
      end
   end

   // Addressed byte and half, big-endian lanes
   assign bsel = readdata[8*(3-ofs_q) +: 8];
   assign hsel = ofs_q[1] ? readdata[15:0] : readdata[31:16];

   // ------------------------------
   always_comb begin
      case (op_q)
         OP_LB:  res = {{24{bsel[7]}}, bsel};
         OP_LBU: res = {24'h0, bsel};
         OP_LH:  res = {{16{hsel[15]}}, hsel};
         OP_LHU: res = {16'h0, hsel};
         // Bytes k..3 to the top, low k bytes of rt kept
         OP_LWL: case (ofs_q)
            2'd0:    res = readdata;
            2'd1:    res = {readdata[23:0], rt_q[7:0]};
            2'd2:    res = {readdata[15:0], rt_q[15:0]};
            default: res = {readdata[7:0], rt_q[23:0]};
         endcase
         // Bytes 0..k to the bottom, upper bytes of rt kept
         OP_LWR: case (ofs_q)
            2'd0:    res = {rt_q[31:8], readdata[31:24]};
            2'd1:    res = {rt_q[31:16], readdata[31:16]};
            2'd2:    res = {rt_q[31:24], readdata[31:8]};
            default: res = readdata;
         endcase
         default: res = readdata;  // LW
      endcase
   end

   // Result registered one cycle after the data beat
   always_ff @(posedge clock) begin
      if (reset)
         load_done <= 1'b0;
      else
         load_done <= readdatavalid;
   end

   always_ff @(posedge clock) begin
      if (readdatavalid)
         load_result <= res;
   end

endmodule

//--- hw/mem_ctrl.sv
/*
   Memory stage control: accepts or restarts requests, drains the store
   buffer onto the data memory bus and issues the single load read.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_ctrl import mem_op_pkg::*, mem_bus_pkg::*; (
   input  logic                       clock,
   input  logic                       reset,
   input  logic                       req,
   input  mem_op_e                    req_op,
   input  logic                       sb_full,
   input  logic                       sb_empty,
   input  sb_entry_t                  sb_head,
   input  logic [`MEM_WADDR_BITS-1:0] load_waddr,
   output logic                       sb_push,
   output logic                       sb_pop,
   output logic                       load_capture,
   output logic                       restart,
   output dmem_cmd_t                  dmem_cmd,
   input  logic                       dmem_waitrequest,
   input  logic                       dmem_readdatavalid
);

   ctrl_state_e                state;
   logic [`MEM_WADDR_BITS-1:0] load_waddr_q;
   logic                       is_load;
   logic                       is_store;
   logic                       refuse;

   // Opcode class
   always_comb begin
      is_load  = 1'b0;
      is_store = 1'b0;
      case (req_op)
         OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR: is_load = 1'b1;
         OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR:                is_store = 1'b1;
         default: ;
      endcase
   end

   // ------------------------------
   // Accept or refuse
   // Loads need an empty buffer, nothing is taken while a load is busy
   assign refuse = req && ((state != IDLE) ||
                           (is_store && sb_full) ||
                           (is_load && !sb_empty));

   assign sb_push      = req && is_store && !refuse;
   assign load_capture = req && is_load && !refuse;

   // Head leaves the buffer as it enters the command register
   assign sb_pop = !dmem_waitrequest && !sb_empty;

   // Word address of the accepted load
   always_ff @(posedge clock) begin
      if (load_capture)
         load_waddr_q <= load_waddr;
   end

   // ------------------------------
   // Command register and FSM
   always_ff @(posedge clock) begin
      if (reset) begin
         restart        <= 1'b0;
         state          <= IDLE;
         dmem_cmd.read  <= 1'b0;
         dmem_cmd.write <= 1'b0;
      end else begin
         // One-cycle pulse, requester reissues
         restart <= refuse;

         // Previous command taken or none pending
         if (!dmem_waitrequest) begin
            dmem_cmd.read  <= 1'b0;
            dmem_cmd.write <= 1'b0;
            if (!sb_empty) begin
               // Writes first
               dmem_cmd.write     <= 1'b1;
               dmem_cmd.waddr     <= sb_head.waddr;
               dmem_cmd.writedata <= sb_head.data;
               dmem_cmd.byteena   <= sb_head.byteena;
            end else if (state == LOAD_ISSUE) begin
               dmem_cmd.read    <= 1'b1;
               dmem_cmd.waddr   <= load_waddr_q;
               dmem_cmd.byteena <= 4'hF;
               state            <= LOAD_WAIT;
            end
         end

         if (load_capture)
            state <= LOAD_ISSUE;

         // Data beat ends the load
         if (state == LOAD_WAIT && dmem_readdatavalid)
            state <= IDLE;
      end
   end

endmodule

//--- hw/mem_stage.sv
/*
   Memory stage top: store alignment, store buffer, control FSM and
   load extraction between the pipeline and the data memory bus.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_stage import mem_op_pkg::*, mem_bus_pkg::*; (
   input  logic                      clock,
   input  logic                      reset,
   input  logic                      req,
   input  mem_req_t                  req_data,
   output logic                      restart,
   output logic                      load_done,
   output logic [`MEM_DATA_BITS-1:0] load_result,
   output dmem_cmd_t                 dmem_cmd,
   input  logic                      dmem_waitrequest,
   input  logic [`MEM_DATA_BITS-1:0] dmem_readdata,
   input  logic                      dmem_readdatavalid
);

   sb_entry_t push_entry;
   sb_entry_t sb_head;
   logic      sb_push;
   logic      sb_pop;
   logic      sb_full;
   logic      sb_empty;
   logic      load_capture;

   // Control
   mem_ctrl u_mem_ctrl (
      .clock              (clock),
      .reset              (reset),
      .req                (req),
      .req_op             (req_data.op),
      .sb_full            (sb_full),
      .sb_empty           (sb_empty),
      .sb_head            (sb_head),
      .load_waddr         (req_data.address[`MEM_ADDR_BITS-1:2]),
      .sb_push            (sb_push),
      .sb_pop             (sb_pop),
      .load_capture       (load_capture),
      .restart            (restart),
      .dmem_cmd           (dmem_cmd),
      .dmem_waitrequest   (dmem_waitrequest),
      .dmem_readdatavalid (dmem_readdatavalid)
   );

   // Store path
   store_align u_store_align (
      .req_data (req_data),
      .entry    (push_entry)
   );

   store_buffer u_store_buffer (
      .clock      (clock),
      .reset      (reset),
      .push       (sb_push),
      .push_entry (push_entry),
      .pop        (sb_pop),
      .head       (sb_head),
      .full       (sb_full),
      .empty      (sb_empty)
   );

   // Load path
   load_extract u_load_extract (
      .clock         (clock),
      .reset         (reset),
      .capture       (load_capture),
      .req_data      (req_data),
      .readdatavalid (dmem_readdatavalid),
      .readdata      (dmem_readdata),
      .load_done     (load_done),
      .load_result   (load_result)
   );

endmodule

//--- verification/mem_stage_props.sv
/*
   Concurrent assertions on the data memory bus and the control pulses.
   Bound into every mem_stage instance.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_stage_props import mem_op_pkg::*, mem_bus_pkg::*; (
   input logic        clock,
   input logic        reset,
   input logic        req,
   input logic        restart,
   input logic        load_done,
   input logic        dmem_waitrequest,
   input logic        dmem_readdatavalid,
   input dmem_cmd_t   dmem_cmd,
   input ctrl_state_e state
);

   // Failed assertions so far, read by the testbench at the end
   int assert_fails = 0;

   // Writes and reads share one command register
   a_one_cmd: assert property (@(posedge clock) disable iff (reset)
      !(dmem_cmd.read && dmem_cmd.write))
      else begin
         $error("dmem read and write set together");
         assert_fails++;
      end

   // Held command must not move under wait-request
   a_cmd_hold: assert property (@(posedge clock) disable iff (reset)
      dmem_waitrequest && (dmem_cmd.read || dmem_cmd.write) |=> $stable(dmem_cmd))
      else begin
         $error("dmem command changed while wait-request was high");
         assert_fails++;
      end

   // Result only after the data beat of a load that was waiting for it
   a_done_after_data: assert property (@(posedge clock) disable iff (reset)
      load_done |-> $past(dmem_readdatavalid && (state == LOAD_WAIT)))
      else begin
         $error("load_done without a data beat for a waiting load");
         assert_fails++;
      end

   // Every restart answers a request one cycle earlier
   a_restart_cause: assert property (@(posedge clock) disable iff (reset)
      restart |-> $past(req))
      else begin
         $error("restart with no request behind it");
         assert_fails++;
      end

endmodule

bind mem_stage mem_stage_props u_mem_stage_props (
   .clock              (clock),
   .reset              (reset),
   .req                (req),
   .restart            (restart),
   .load_done          (load_done),
   .dmem_waitrequest   (dmem_waitrequest),
   .dmem_readdatavalid (dmem_readdatavalid),
   .dmem_cmd           (dmem_cmd),
   .state              (u_mem_ctrl.state)
);

//--- verification/mem_stage_checker.sv
/*
   Reference model of the memory stage. Tracks accepted stores in its own
   memory, predicts load results and keeps per-test and total counts.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_stage_checker import mem_op_pkg::*; (
   input logic                      clock,
   input logic                      reset,
   input logic                      req,
   input mem_req_t                  req_data,
   input logic                      restart,
   input logic                      load_done,
   input logic [`MEM_DATA_BITS-1:0] load_result
);

   logic [31:0] mem [256];
   logic        prev_req;
   mem_req_t    prev_data;
   logic        load_pending;
   logic [31:0] load_expect;
   string       test_name = "none";
   int          test_checks;
   int          test_errors;
   int          total_checks;
   int          total_errors;

   // Byte j of a word, byte 0 is bits 31:24
   function automatic logic [7:0] byte_of(input logic [31:0] w, input int j);
      return w[31-8*j -: 8];
   endfunction

   // Same fill the memory model starts from
   function automatic logic [31:0] fill_word(input logic [7:0] i);
      return {i, ~i, i ^ 8'h5a, i + 8'h3c};
   endfunction

   function automatic logic [31:0] store_merge(input logic [31:0] old, input mem_op_e op,
                                               input int k, input logic [31:0] rt);
      logic [31:0] w;
      w = old;
      for (int j = 0; j < 4; j++) begin
         case (op)
            OP_SW:  w[31-8*j -: 8] = byte_of(rt, j);
            OP_SH:  if (j / 2 == k / 2) w[31-8*j -: 8] = byte_of(rt, 2 + j % 2);
            OP_SB:  if (j == k) w[31-8*j -: 8] = byte_of(rt, 3);
            // Top 4-k bytes of rt into bytes k..3
            OP_SWL: if (j >= k) w[31-8*j -: 8] = byte_of(rt, j - k);
            // Low k+1 bytes of rt into bytes 0..k
            OP_SWR: if (j <= k) w[31-8*j -: 8] = byte_of(rt, 3 - k + j);
            default: ;
         endcase
      end
      return w;
   endfunction

   function automatic logic [31:0] load_pick(input logic [31:0] w, input mem_op_e op,
                                             input int k, input logic [31:0] rt);
      logic [7:0]  b;
      logic [15:0] h;
      logic [31:0] r;
      b = byte_of(w, k);
      h = {byte_of(w, 2 * (k / 2)), byte_of(w, 2 * (k / 2) + 1)};
      r = rt;
      case (op)
         OP_LB:  r = {{24{b[7]}}, b};
         OP_LBU: r = {24'h0, b};
         OP_LH:  r = {{16{h[15]}}, h};
         OP_LHU: r = {16'h0, h};
         OP_LWL: for (int j = 0; j <= 3 - k; j++) r[31-8*j -: 8] = byte_of(w, k + j);
         OP_LWR: for (int j = 3 - k; j < 4; j++) r[31-8*j -: 8] = byte_of(w, j - (3 - k));
         default: r = w;
      endcase
      return r;
   endfunction

   // ------------------------------
   task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
      test_checks++;
      if (expected !== actual) begin
         test_errors++;
         $display("ERROR %s %s: expected %08h actual %08h", test_name, what, expected, actual);
      end
   endtask

   task automatic check_mem_word(input int idx, input logic [31:0] actual);
      check($sformatf("memory word %0d", idx), mem[idx], actual);
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic end_test();
      $display("%-22s %s  checks %0d errors %0d", test_name,
               (test_errors == 0) ? "ok" : "FAILING", test_checks, test_errors);
      total_checks += test_checks;
      total_errors += test_errors;
   endtask

   task automatic report_counts();
      $display("total checks %0d errors %0d", total_checks, total_errors);
   endtask

   // ------------------------------
   // A request seen last edge is accepted unless restart answers it now
   always @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < 256; i++)
            mem[i] = fill_word(i[7:0]);
         prev_req     = 1'b0;
         load_pending = 1'b0;
      end else begin
         if (prev_req && !restart) begin
            if (prev_data.op inside {OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR})
               mem[prev_data.address[9:2]] = store_merge(mem[prev_data.address[9:2]],
                  prev_data.op, int'(prev_data.address[1:0]), prev_data.rt_val);
            else begin
               load_expect  = load_pick(mem[prev_data.address[9:2]], prev_data.op,
                                        int'(prev_data.address[1:0]), prev_data.rt_val);
               load_pending = 1'b1;
            end
         end
         if (load_done) begin
            if (load_pending)
               check("load result", load_expect, load_result);
            else begin
               test_errors++;
               $display("%s: load_done pulsed with no load in flight", test_name);
            end
            load_pending = 1'b0;
         end
         prev_req  = req;
         prev_data = req_data;
      end
   end

endmodule

//--- verification/mem_stage_tb.sv
/*
   Testbench for the memory stage: clock, reset, xorshift stimulus and a
   256-word data memory model with random wait-request and read latency.
*/
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_stage_tb import mem_op_pkg::*, mem_bus_pkg::*; ();

   logic                      clock;
   logic                      reset;
   logic                      req;
   mem_req_t                  req_data;
   logic                      restart;
   logic                      load_done;
   logic [`MEM_DATA_BITS-1:0] load_result;
   dmem_cmd_t                 dmem_cmd;
   logic                      dmem_waitrequest;
   logic [`MEM_DATA_BITS-1:0] dmem_readdata;
   logic                      dmem_readdatavalid;

   logic [31:0] mem [256];
   logic [31:0] rng;
   logic [31:0] bus_rng;
   logic        hold_wait;
   logic [2:0]  rd_count;
   logic [7:0]  rd_addr;
   logic        timed_out;

   mem_stage u_mem_stage (.*);

   mem_stage_checker u_checker (
      .clock       (clock),
      .reset       (reset),
      .req         (req),
      .req_data    (req_data),
      .restart     (restart),
      .load_done   (load_done),
      .load_result (load_result)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   // ------------------------------
   // Data memory model, byteena bit i covers bits 8i+7:8i
   always @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < 256; i++)
            mem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'h3c};
         dmem_waitrequest   <= 1'b0;
         dmem_readdatavalid <= 1'b0;
         rd_count           <= '0;
      end else begin
         bus_rng = xorshift(bus_rng);
         dmem_waitrequest   <= hold_wait | bus_rng[0];
         dmem_readdatavalid <= 1'b0;
         if (dmem_cmd.write && !dmem_waitrequest)
            for (int i = 0; i < 4; i++)
               if (dmem_cmd.byteena[i])
                  mem[dmem_cmd.waddr[7:0]][8*i +: 8] <= dmem_cmd.writedata[8*i +: 8];
         // Read latency 1 to 4 cycles
         if (dmem_cmd.read && !dmem_waitrequest) begin
            rd_count <= 3'd1 + bus_rng[3:2];
            rd_addr  <= dmem_cmd.waddr[7:0];
         end else if (rd_count != 0) begin
            if (rd_count == 1) begin
               dmem_readdatavalid <= 1'b1;
               dmem_readdata      <= mem[rd_addr];
            end
            rd_count <= rd_count - 1'b1;
         end
      end
   end

   // ------------------------------
   task automatic roll(output logic [31:0] r);
      rng = xorshift(rng);
      r   = rng;
   endtask

   // Later waits fall straight through once one has run out
   task automatic note_timeout(input string why);
      $display("timeout: %s", why);
      timed_out = 1'b1;
   endtask

   // One request, answer sampled the edge after restart would rise
   task automatic issue(input mem_op_e op, input logic [9:0] addr, input logic [31:0] rt,
                        output logic refused);
      @(posedge clock);
      req      <= 1'b1;
      req_data <= '{op: op, address: {22'h0, addr}, rt_val: rt};
      @(posedge clock);
      req <= 1'b0;
      @(posedge clock);
      refused = restart;
   endtask

   task automatic issue_accepted(input mem_op_e op, input logic [9:0] addr,
                                 input logic [31:0] rt);
      logic refused;
      int   tries;
      refused = 1'b1;
      tries   = 0;
      while (refused && tries < 64 && !timed_out) begin
         issue(op, addr, rt, refused);
         tries++;
      end
      if (refused && !timed_out)
         note_timeout("request kept getting restart");
   endtask

   task automatic load_word(input mem_op_e op, input logic [9:0] addr, input logic [31:0] rt);
      logic seen;
      seen = 1'b0;
      issue_accepted(op, addr, rt);
      for (int n = 0; n < 100 && !seen && !timed_out; n++) begin
         @(posedge clock);
         seen = load_done;
      end
      if (!seen && !timed_out)
         note_timeout("load_done never came");
   endtask

   // ------------------------------
   initial begin
      logic [31:0] r;
      logic [31:0] rt;
      logic [7:0]  idx;
      logic        refused;
      logic        got [8];
      logic [9:0]  last_addr;
      req                = 1'b0;
      req_data           = '0;
      dmem_waitrequest   = 1'b0;
      dmem_readdata      = '0;
      dmem_readdatavalid = 1'b0;
      hold_wait          = 1'b0;
      timed_out          = 1'b0;
      reset              = 1'b1;
      rng                = 32'ha3a2;
      bus_rng            = xorshift(32'ha3a2);
      repeat (16) @(posedge clock);
      reset <= 1'b0;

      u_checker.start_test("reset_idle");
      repeat (20) begin
         @(posedge clock);
         u_checker.check("idle outputs", 0,
                         32'({dmem_cmd.read, dmem_cmd.write, restart, load_done}));
      end
      u_checker.end_test();

      u_checker.start_test("store_word_half_byte");
      repeat (12) begin
         roll(r);
         idx = r[7:0];
         roll(r);
         issue_accepted(OP_SW, {idx, 2'b00}, r);
         roll(r);
         issue_accepted(OP_SH, {idx, r[9], 1'b0}, r);
         roll(r);
         issue_accepted(OP_SB, {idx, r[9:8]}, r);
         load_word(OP_LW, {idx, 2'b00}, r);
      end
      u_checker.end_test();

      u_checker.start_test("load_extend");
      repeat (12) begin
         roll(r);
         idx = r[7:0];
         roll(r);
         issue_accepted(OP_SW, {idx, 2'b00}, r);
         load_word(OP_LB, {idx, r[1:0]}, r);
         load_word(OP_LBU, {idx, r[3:2]}, r);
         load_word(OP_LH, {idx, r[4], 1'b0}, r);
         load_word(OP_LHU, {idx, r[5], 1'b0}, r);
      end
      u_checker.end_test();

      u_checker.start_test("partial_word");
      repeat (16) begin
         roll(r);
         idx = r[7:0];
         roll(rt);
         issue_accepted(rt[31] ? OP_SWL : OP_SWR, {idx, r[9:8]}, rt);
         roll(rt);
         load_word(r[12] ? OP_LWL : OP_LWR, {idx, r[11:10]}, rt);
      end
      u_checker.end_test();

      // Nothing drains, so one slot of eight stays free
      u_checker.start_test("buffer_full");
      @(posedge clock);
      hold_wait <= 1'b1;
      repeat (3) @(posedge clock);
      for (int i = 0; i < 10; i++) begin
         @(posedge clock);
         if (i >= 2)
            got[i-2] = restart;
         if (i < 8) begin
            roll(r);
            last_addr = {r[7:0], 2'b00};
            req      <= 1'b1;
            req_data <= '{op: OP_SW, address: {22'h0, last_addr}, rt_val: r};
         end else
            req <= 1'b0;
      end
      for (int i = 0; i < 8; i++)
         u_checker.check($sformatf("restart of store %0d", i), 32'(i == 7), 32'(got[i]));
      hold_wait <= 1'b0;
      issue_accepted(OP_SW, last_addr, r);
      load_word(OP_LW, last_addr, 0);
      for (int i = 0; i < 256; i++)
         u_checker.check_mem_word(i, mem[i]);
      u_checker.end_test();

      u_checker.start_test("load_after_store");
      repeat (4) begin
         @(posedge clock);
         hold_wait <= 1'b1;
         repeat (3) @(posedge clock);
         roll(r);
         idx = r[7:0];
         issue_accepted(OP_SW, {idx, 2'b00}, r);
         roll(r);
         issue_accepted(OP_SB, {idx, r[1:0]}, r);
         issue(OP_LW, {idx, 2'b00}, 0, refused);
         u_checker.check("load behind stores refused", 1, 32'(refused));
         hold_wait <= 1'b0;
         load_word(OP_LW, {idx, 2'b00}, 0);
      end
      u_checker.end_test();

      u_checker.report_counts();
      if (!timed_out && u_checker.total_errors == 0 &&
          u_mem_stage.u_mem_stage_props.assert_fails == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- flist.f
+incdir+hw
hw/mem_op_pkg.sv
hw/mem_bus_pkg.sv
hw/store_align.sv
hw/store_buffer.sv
hw/load_extract.sv
hw/mem_ctrl.sv
hw/mem_stage.sv
verification/mem_stage_props.sv
verification/mem_stage_checker.sv
verification/mem_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wall
TOP       ?= mem_stage_tb
FLIST     ?= flist.f
LOG       ?= sim.log

SHELL := /bin/bash

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST)
	set -o pipefail; ./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
